/* design/tape_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Shared widths and state encodings for the tape path
//////////////////////////////////////////////////////////////////////

package tape_pkg;

	localparam int BYTE_W = 8;  // One tape image byte

	// Download loader FSM
	typedef enum logic {
		LOAD_IDLE  = 1'b0,
		LOAD_WRITE = 1'b1   // Wishbone write in flight
	} loader_state_e;

	// Playback fetcher FSM
	typedef enum logic {
		FETCH_IDLE = 1'b0,
		FETCH_READ = 1'b1   // Wishbone read in flight
	} fetch_state_e;

	// Owner of the tape memory for the current transfer
	typedef enum logic [1:0] {
		GRANT_NONE    = 2'd0,
		GRANT_LOADER  = 2'd1,
		GRANT_FETCHER = 2'd2
	} grant_e;

endpackage

`default_nettype wire

/* design/tape_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module tape_loader #(
	parameter int ADDR_W = 12
) (
	input  logic                        clk_sys,
	input  logic                        reset,

	// Host download side
	input  logic                        dl_active,
	input  logic                        dl_wr,
	input  logic [ADDR_W-1:0]           dl_addr,
	input  logic [tape_pkg::BYTE_W-1:0] dl_data,

	// Wishbone master towards the tape memory
	output logic                        ld_cyc,
	output logic                        ld_stb,
	output logic                        ld_we,
	output logic [ADDR_W-1:0]           ld_adr,
	output logic [tape_pkg::BYTE_W-1:0] ld_dat_w,
	input  logic                        ld_ack,

	// Image status for playback
	output logic [ADDR_W:0]             tape_len,
	output logic                        tape_restart
);

	tape_pkg::loader_state_e state;

	logic            dl_wr_q;
	logic            dl_active_q;
	logic            wr_edge;
	logic [ADDR_W:0] next_len;

	// New byte from the host, only counts while a download runs
	assign wr_edge = dl_active & dl_wr & ~dl_wr_q;

	// Length if the byte now being acked is the highest so far
	assign next_len = {1'b0, ld_adr} + {{ADDR_W{1'b0}}, 1'b1};

	assign ld_cyc = (state == tape_pkg::LOAD_WRITE);
	assign ld_stb = ld_cyc;
	assign ld_we  = ld_cyc;  // Loader only ever writes

	//////////////////////////////////////////////////////////////////////
	// Control state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state        <= tape_pkg::LOAD_IDLE;
			dl_wr_q      <= 1'b0;
			dl_active_q  <= 1'b0;
			tape_len     <= '0;
			tape_restart <= 1'b0;
		end else begin
			dl_wr_q      <= dl_wr;
			dl_active_q  <= dl_active;
			tape_restart <= dl_active_q & ~dl_active;  // End of download

			case (state)
				tape_pkg::LOAD_IDLE: begin
					if (wr_edge)
						state <= tape_pkg::LOAD_WRITE;
				end
				tape_pkg::LOAD_WRITE: begin
					// Edges seen here are dropped by design
					if (ld_ack)
						state <= tape_pkg::LOAD_IDLE;
				end
				default: state <= tape_pkg::LOAD_IDLE;
			endcase

			// Fresh image starts empty
			if (dl_active & ~dl_active_q)
				tape_len <= '0;
			else if (ld_ack && next_len > tape_len)
				tape_len <= next_len;
		end
	end

	// Captured write payload, held until ack
	always_ff @(posedge clk_sys) begin
		if (state == tape_pkg::LOAD_IDLE && wr_edge) begin
			ld_adr   <= dl_addr;
			ld_dat_w <= dl_data;
		end
	end

endmodule

`default_nettype wire

/* design/tape_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tape_buffer #(
	parameter int ADDR_W = 12
) (
	input  logic                        clk_sys,
	input  logic                        reset,

	// Loader port, write side
	input  logic                        ld_cyc,
	input  logic                        ld_stb,
	input  logic                        ld_we,
	input  logic [ADDR_W-1:0]           ld_adr,
	input  logic [tape_pkg::BYTE_W-1:0] ld_dat_w,
	output logic                        ld_ack,

	// Fetcher port, read only
	input  logic                        fe_cyc,
	input  logic                        fe_stb,
	input  logic [ADDR_W-1:0]           fe_adr,
	output logic [tape_pkg::BYTE_W-1:0] fe_dat_r,
	output logic                        fe_ack
);

	localparam int DEPTH = 1 << ADDR_W;

	logic [tape_pkg::BYTE_W-1:0] mem [DEPTH];

	tape_pkg::grant_e grant;

	logic ld_req;
	logic fe_req;
	logic ld_go;
	logic fe_go;

	assign ld_req = ld_cyc & ld_stb;
	assign fe_req = fe_cyc & fe_stb;

	// Access happens once per grant, in the cycle before ack
	assign ld_go = (grant == tape_pkg::GRANT_LOADER) & ld_req & ~ld_ack;
	assign fe_go = (grant == tape_pkg::GRANT_FETCHER) & fe_req & ~fe_ack;

	//////////////////////////////////////////////////////////////////////
	// Arbiter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			grant <= tape_pkg::GRANT_NONE;
		end else begin
			case (grant)
				tape_pkg::GRANT_NONE: begin
					if (ld_req)
						grant <= tape_pkg::GRANT_LOADER;  // Loader wins ties
					else if (fe_req)
						grant <= tape_pkg::GRANT_FETCHER;
				end
				tape_pkg::GRANT_LOADER: begin
					// Release on ack, or if the master gives up
					if (ld_ack || !ld_req)
						grant <= tape_pkg::GRANT_NONE;
				end
				tape_pkg::GRANT_FETCHER: begin
					if (fe_ack || !fe_req)
						grant <= tape_pkg::GRANT_NONE;
				end
				default: grant <= tape_pkg::GRANT_NONE;
			endcase
		end
	end

	// Single cycle acks
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ld_ack <= 1'b0;
			fe_ack <= 1'b0;
		end else begin
			ld_ack <= ld_go;
			fe_ack <= fe_go;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Tape memory
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (ld_go && ld_we)
			mem[ld_adr] <= ld_dat_w;
	end

	// Read data lands together with fe_ack
	always_ff @(posedge clk_sys) begin
		if (fe_go)
			fe_dat_r <= mem[fe_adr];
	end

endmodule

`default_nettype wire

/* design/tape_fetcher.sv */
`timescale 1ns/1ps
`default_nettype none

module tape_fetcher #(
	parameter int ADDR_W = 12
) (
	input  logic                        clk_sys,
	input  logic                        reset,

	// Player toggle handshake
	input  logic                        tape_req,
	output logic                        tape_ack,
	output logic [tape_pkg::BYTE_W-1:0] tape_data,

	// Image status from the loader
	input  logic [ADDR_W:0]             tape_len,
	input  logic                        tape_restart,

	// Wishbone master, read only
	output logic                        fe_cyc,
	output logic                        fe_stb,
	output logic [ADDR_W-1:0]           fe_adr,
	input  logic [tape_pkg::BYTE_W-1:0] fe_dat_r,
	input  logic                        fe_ack
);

	tape_pkg::fetch_state_e state;

	logic [ADDR_W:0] play_addr;   // Next byte to hand out
	logic            pending;
	logic            have_byte;
	logic            stale;       // Restart hit a read in flight

	assign pending   = tape_req ^ tape_ack;
	assign have_byte = play_addr < tape_len;

	assign fe_cyc = (state == tape_pkg::FETCH_READ);
	assign fe_stb = fe_cyc;

	//////////////////////////////////////////////////////////////////////
	// Fetch FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= tape_pkg::FETCH_IDLE;
			play_addr <= '0;
			tape_ack  <= 1'b0;
			stale     <= 1'b0;
		end else begin
			case (state)
				tape_pkg::FETCH_IDLE: begin
					if (pending && have_byte && !tape_restart) begin
						state <= tape_pkg::FETCH_READ;
						stale <= 1'b0;
					end
				end
				tape_pkg::FETCH_READ: begin
					if (tape_restart)
						stale <= 1'b1;
					if (fe_ack) begin
						state <= tape_pkg::FETCH_IDLE;
						// A stale byte is thrown away; request stays pending
						if (!stale && !tape_restart) begin
							tape_ack  <= ~tape_ack;  // Answer the player
							play_addr <= play_addr + 1'b1;
						end
					end
				end
				default: state <= tape_pkg::FETCH_IDLE;
			endcase

			// New image, rewind
			if (tape_restart)
				play_addr <= '0;
		end
	end

	// Read address held for the whole transfer
	always_ff @(posedge clk_sys) begin
		if (state == tape_pkg::FETCH_IDLE)
			fe_adr <= play_addr[ADDR_W-1:0];
	end

	// Byte to the player, stays until the next answer
	always_ff @(posedge clk_sys) begin
		if (state == tape_pkg::FETCH_READ && fe_ack && !stale && !tape_restart)
			tape_data <= fe_dat_r;
	end

endmodule

`default_nettype wire

/* design/tape_stream.sv */
`timescale 1ns/1ps
`default_nettype none

module tape_stream #(
	parameter int ADDR_W = 12
) (
	input  logic                        clk_sys,
	input  logic                        reset,

	// Host download
	input  logic                        dl_active,
	input  logic                        dl_wr,
	input  logic [ADDR_W-1:0]           dl_addr,
	input  logic [tape_pkg::BYTE_W-1:0] dl_data,

	// Tape player
	input  logic                        tape_req,
	output logic                        tape_ack,
	output logic [tape_pkg::BYTE_W-1:0] tape_data,
	output logic                        tape_restart
);

	//////////////////////////////////////////////////////////////////////
	// Internal buses
	//////////////////////////////////////////////////////////////////////

	logic                        ld_cyc;
	logic                        ld_stb;
	logic                        ld_we;
	logic [ADDR_W-1:0]           ld_adr;
	logic [tape_pkg::BYTE_W-1:0] ld_dat_w;
	logic                        ld_ack;

	logic                        fe_cyc;
	logic                        fe_stb;
	logic [ADDR_W-1:0]           fe_adr;
	logic [tape_pkg::BYTE_W-1:0] fe_dat_r;
	logic                        fe_ack;

	logic [ADDR_W:0]             tape_len;  // Bytes in the current image

	tape_loader #(.ADDR_W(ADDR_W)) i_tape_loader (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.ld_cyc       (ld_cyc),
		.ld_stb       (ld_stb),
		.ld_we        (ld_we),
		.ld_adr       (ld_adr),
		.ld_dat_w     (ld_dat_w),
		.ld_ack       (ld_ack),
		.tape_len     (tape_len),
		.tape_restart (tape_restart)
	);

	tape_buffer #(.ADDR_W(ADDR_W)) i_tape_buffer (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ld_cyc   (ld_cyc),
		.ld_stb   (ld_stb),
		.ld_we    (ld_we),
		.ld_adr   (ld_adr),
		.ld_dat_w (ld_dat_w),
		.ld_ack   (ld_ack),
		.fe_cyc   (fe_cyc),
		.fe_stb   (fe_stb),
		.fe_adr   (fe_adr),
		.fe_dat_r (fe_dat_r),
		.fe_ack   (fe_ack)
	);

	tape_fetcher #(.ADDR_W(ADDR_W)) i_tape_fetcher (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.tape_req     (tape_req),
		.tape_ack     (tape_ack),
		.tape_data    (tape_data),
		.tape_len     (tape_len),
		.tape_restart (tape_restart),
		.fe_cyc       (fe_cyc),
		.fe_stb       (fe_stb),
		.fe_adr       (fe_adr),
		.fe_dat_r     (fe_dat_r),
		.fe_ack       (fe_ack)
	);

endmodule

`default_nettype wire

/* dv/tape_stream_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module tape_stream_properties (
	input logic             clk_sys,
	input logic             reset,
	input logic             ld_cyc,
	input logic             ld_stb,
	input logic             ld_ack,
	input logic             fe_cyc,
	input logic             fe_stb,
	input logic             fe_ack,
	input tape_pkg::grant_e grant
);

	//////////////////////////////////////////////////////////////////////
	// Wishbone slave side rules
	//////////////////////////////////////////////////////////////////////

	a_ld_ack_with_req: assert property (@(posedge clk_sys) disable iff (reset)
		ld_ack |-> (ld_cyc && ld_stb && grant == tape_pkg::GRANT_LOADER))
		else $error("ld_ack without a granted loader cycle");

	a_fe_ack_with_req: assert property (@(posedge clk_sys) disable iff (reset)
		fe_ack |-> (fe_cyc && fe_stb && grant == tape_pkg::GRANT_FETCHER))
		else $error("fe_ack without a granted fetcher cycle");

	// Acks last one cycle
	a_ld_ack_single: assert property (@(posedge clk_sys) disable iff (reset)
		ld_ack |=> !ld_ack)
		else $error("ld_ack held longer than one cycle");

	a_fe_ack_single: assert property (@(posedge clk_sys) disable iff (reset)
		fe_ack |=> !fe_ack)
		else $error("fe_ack held longer than one cycle");

	a_acks_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(ld_ack && fe_ack))
		else $error("ld_ack and fe_ack high together");

	// Masters keep strobing until served
	a_ld_stb_held: assert property (@(posedge clk_sys) disable iff (reset)
		(ld_stb && !ld_ack) |=> ld_stb)
		else $error("ld_stb dropped before ld_ack");

	a_fe_stb_held: assert property (@(posedge clk_sys) disable iff (reset)
		(fe_stb && !fe_ack) |=> fe_stb)
		else $error("fe_stb dropped before fe_ack");

endmodule

`default_nettype wire

/* dv/tape_stream_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tape_stream_tb;

	localparam int ADDR_W       = 8;
	localparam int ANSWER_LIMIT = 100;  // Cycles allowed per player answer

	logic                        clk_sys;
	logic                        reset;
	logic                        dl_active;
	logic                        dl_wr;
	logic [ADDR_W-1:0]           dl_addr;
	logic [tape_pkg::BYTE_W-1:0] dl_data;
	logic                        tape_req;
	logic                        tape_ack;
	logic [tape_pkg::BYTE_W-1:0] tape_data;
	logic                        tape_restart;

	logic [tape_pkg::BYTE_W-1:0] model_mem [1 << ADDR_W];  // Tape image model
	int                          play_pos;
	int                          restart_count;
	int                          len_a;
	int                          len_b;
	int                          part;

	tape_stream #(.ADDR_W(ADDR_W)) i_tape_stream (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.tape_req     (tape_req),
		.tape_ack     (tape_ack),
		.tape_data    (tape_data),
		.tape_restart (tape_restart)
	);

	bind tape_buffer tape_stream_properties i_tape_stream_properties (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ld_cyc  (ld_cyc),
		.ld_stb  (ld_stb),
		.ld_ack  (ld_ack),
		.fe_cyc  (fe_cyc),
		.fe_stb  (fe_stb),
		.fe_ack  (fe_ack),
		.grant   (grant)
	);

	always #20 clk_sys = ~clk_sys;

	always @(negedge clk_sys) begin
		if (!reset && tape_restart)
			restart_count <= restart_count + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	// Host writes len random bytes from address 0
	task automatic run_download(input int len);
		int gap;
		int start_count;
		int n;
		start_count = restart_count;
		@(posedge clk_sys);
		dl_active <= 1'b1;
		repeat (2) @(posedge clk_sys);
		for (int i = 0; i < len; i++) begin
			model_mem[i] = 8'($urandom_range(255, 0));
			gap = $urandom_range(10, 6);  // Rising edge to rising edge
			dl_addr <= ADDR_W'(i);
			dl_data <= model_mem[i];
			dl_wr   <= 1'b1;
			@(posedge clk_sys);
			dl_wr <= 1'b0;
			repeat (gap - 1) @(posedge clk_sys);
		end
		repeat (10) @(posedge clk_sys);
		check_value("restart_count", 32'(restart_count), 32'(start_count));
		dl_active <= 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (restart_count == start_count) begin
			if (n >= 20) begin
				$display("No tape_restart pulse after the download ended");
				$display("SOME TESTS FAILED");
				$fatal(1, "restart timeout");
			end else begin
				@(negedge clk_sys);
				n++;
			end
		end
		repeat (10) @(negedge clk_sys);
		check_value("restart_count", 32'(restart_count), 32'(start_count + 1));
		play_pos = 0;  // Playback starts over
	endtask

	task automatic wait_for_answer();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (tape_ack !== tape_req) begin
			if (n >= ANSWER_LIMIT) begin
				$display("Player request was never answered by tape_ack");
				$display("SOME TESTS FAILED");
				$fatal(1, "answer timeout");
			end else begin
				@(negedge clk_sys);
				n++;
			end
		end
	endtask

	task automatic request_byte(input int delay);
		repeat (delay) @(posedge clk_sys);
		@(posedge clk_sys);
		tape_req <= ~tape_req;
		wait_for_answer();
		check_value("tape_data", 32'(tape_data), 32'(model_mem[play_pos]));
		play_pos++;
	endtask

	// Request that must stay pending for the whole window
	task automatic request_unanswered(input int window);
		@(posedge clk_sys);
		tape_req <= ~tape_req;
		repeat (window) begin
			@(negedge clk_sys);
			if (tape_ack === tape_req) begin
				$display("tape_ack answered a request with no byte left to play");
				$display("SOME TESTS FAILED");
				$fatal(1, "unexpected answer");
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h50e4_bec6));
		clk_sys       = 1'b0;
		reset         = 1'b1;
		dl_active     = 1'b0;
		dl_wr         = 1'b0;
		dl_addr       = '0;
		dl_data       = '0;
		tape_req      = 1'b0;
		play_pos      = 0;
		restart_count = 0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check_value("tape_ack", 32'(tape_ack), 32'h0);
		check_value("tape_restart", 32'(tape_restart), 32'h0);

		request_unanswered(50);  // Empty tape

		// First image, early request gets byte 0 once it lands
		len_a = $urandom_range(200, 2);
		run_download(len_a);
		check_value("tape_ack", 32'(tape_ack), 32'(tape_req));
		check_value("tape_data", 32'(tape_data), 32'(model_mem[0]));

		part = $urandom_range(len_a - 1, 1);
		for (int i = 0; i < part; i++)
			request_byte($urandom_range(20, 0));

		// Shorter image part-way through playback
		len_b = $urandom_range(len_a - 1, 1);
		run_download(len_b);
		for (int i = 0; i < len_b; i++)
			request_byte($urandom_range(20, 0));
		request_unanswered(100);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tape_stream.f */
design/tape_pkg.sv
design/tape_loader.sv
design/tape_buffer.sv
design/tape_fetcher.sv
design/tape_stream.sv
dv/tape_stream_properties.sv
dv/tape_stream_tb.sv

/* Makefile */
# Verilator build and run for the tape stream testbench

VERILATOR  ?= verilator
TOP        := tape_stream_tb
FILELIST   := tape_stream.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run's exit status is the test result
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
